// ==== Makefile ====
TOP := vmul_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

// ==== common/vec_data_pkg.sv ====
// data-side types of the vector multiply unit
// element width code and the operand word
`include "vmul_cfg.svh"

package vec_data_pkg;

    // element width, same encoding as the vsew field
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // one operand or result word, holds 8/4/2/1 packed elements
    typedef logic [`VMUL_DATA_W-1:0] bus64_t;

endpackage

// ==== common/vmul_cfg.svh ====
// vector multiply unit configuration
// operand, tag and pipeline sizes shared by the whole unit
`ifndef VMUL_CFG_SVH
`define VMUL_CFG_SVH

// operand and result word width
`define VMUL_DATA_W 64

// destination register tag width
`define VMUL_TAG_W 5

// request to response, in clock cycles
`define VMUL_LATENCY 2

`endif

// ==== common/vmul_op_pkg.sv ====
// operation-side types of the vector multiply unit
// opcodes, decoded operations, request and response
`include "vmul_cfg.svh"

package vmul_op_pkg;

    import vec_data_pkg::*;

    // funct6 encodings of the supported multiplies
    typedef enum logic [5:0] {
        F6_VMULHU  = 6'b100100,
        F6_VMUL    = 6'b100101,
        F6_VMULHSU = 6'b100110,
        F6_VMULH   = 6'b100111
    } vmul_funct6_t;

    // decoded operation
    typedef enum logic [1:0] {
        VMUL,
        VMULH,
        VMULHU,
        VMULHSU
    } instr_type_t;

    // incoming request, raw fields straight from the issue side
    typedef struct packed {
        logic                   valid;
        vmul_funct6_t           funct6;
        logic [2:0]             vsew;
        logic [`VMUL_TAG_W-1:0] vd;
        bus64_t                 vs1;
        bus64_t                 vs2;
    } vmul_req_t;

    // outgoing response
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic [`VMUL_TAG_W-1:0] vd;
        bus64_t                 data;
    } vmul_rsp_t;

endpackage

// ==== source/vmul_unit.sv ====
// vector integer multiply unit top level
// decoder, SIMD multiplier and writeback, fixed two-cycle latency
`timescale 1ns/1ps

module vmul_unit
    import vec_data_pkg::*;
    import vmul_op_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  vmul_req_t req_i,
    output vmul_rsp_t rsp_o
);

    instr_type_t instr_type;
    sew_t        sew;
    logic        illegal;
    bus64_t      data_vd;

    // combinational decode of the raw opcode and width
    vmul_decode i_vmul_decode (
        .funct6_i     (req_i.funct6),
        .vsew_i       (req_i.vsew),
        .instr_type_o (instr_type),
        .sew_o        (sew),
        .illegal_o    (illegal)
    );

    // operands go straight from the request
    vmul i_vmul (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .instr_type_i (instr_type),
        .sew_i        (sew),
        .data_vs1_i   (req_i.vs1),
        .data_vs2_i   (req_i.vs2),
        .data_vd_o    (data_vd)
    );

    vmul_wb i_vmul_wb (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_i      (req_i.valid),
        .vd_i         (req_i.vd),
        .illegal_i    (illegal),
        .data_i       (data_vd),
        .rsp_o        (rsp_o)
    );

endmodule

// ==== tb/vmul_unit_tb.sv ====
// testbench for the vector multiply unit
// random requests from a fixed seed, checked against an element-wise model
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_unit_tb
    import vec_data_pkg::*;
    import vmul_op_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    localparam int N_TESTS      = 2000;
    // reset, tests, drain, plus margin
    localparam int MAX_CYCLES   = RESET_CYCLES + N_TESTS + 84;

    logic      clk_i;
    logic      rstn_i;
    vmul_req_t req_i;
    vmul_rsp_t rsp_o;
    int        cycles;

    // expected responses, one entry per driven cycle, oldest first
    logic                   exp_valid_q[$];
    logic                   exp_illegal_q[$];
    logic [`VMUL_TAG_W-1:0] exp_vd_q[$];
    bus64_t                 exp_data_q[$];
    string                  exp_name_q[$];

    vmul_unit i_vmul_unit (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (req_i),
        .rsp_o  (rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic is_legal(input logic [5:0] f6, input logic [2:0] vsew);
        return (f6 == F6_VMUL || f6 == F6_VMULH || f6 == F6_VMULHU || f6 == F6_VMULHSU)
               && (vsew < 3'd4);
    endfunction

    // exact double-width product per element, low or high half kept
    function automatic bus64_t model_result(input logic [5:0] f6, input logic [2:0] vsew,
                                            input bus64_t vs1, input bus64_t vs2);
        int           w;
        logic         high;
        logic         s1;
        logic         s2;
        logic [127:0] mask;
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] prod;
        bus64_t       result;
        w      = 8 << vsew;
        high   = (f6 != F6_VMUL);
        // vmulhsu: vs2 signed, vs1 unsigned
        s1     = (f6 == F6_VMUL) || (f6 == F6_VMULH);
        s2     = (f6 != F6_VMULHU);
        mask   = (128'd1 << w) - 128'd1;
        result = '0;
        for (int i = 0; i < 64 / w; i++) begin
            ea = ({64'd0, vs1} >> (i * w)) & mask;
            eb = ({64'd0, vs2} >> (i * w)) & mask;
            // sign extend to 128 bits
            if (s1 && ea[w-1]) ea = ea | ~mask;
            if (s2 && eb[w-1]) eb = eb | ~mask;
            prod = ea * eb;
            if (high) prod = prod >> w;
            result = result | (64'(prod & mask) << (i * w));
        end
        return result;
    endfunction

    function automatic string op_name(input logic [5:0] f6);
        case (f6)
            F6_VMUL:    return "vmul";
            F6_VMULH:   return "vmulh";
            F6_VMULHU:  return "vmulhu";
            F6_VMULHSU: return "vmulhsu";
            default:    return "bad_funct6";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and checking
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // operand word, sometimes a most-negative pattern per width
    function automatic bus64_t rand_operand();
        case ($urandom % 16)
            0:       return 64'h8080_8080_8080_8080;
            1:       return 64'h8000_8000_8000_8000;
            2:       return 64'h8000_0000_8000_0000;
            3:       return 64'h8000_0000_0000_0000;
            4:       return '1;
            default: return {$urandom, $urandom};
        endcase
    endfunction

    task automatic push_expected(input logic valid, input logic illegal,
                                 input logic [`VMUL_TAG_W-1:0] vd, input bus64_t data,
                                 input string name);
        exp_valid_q.push_back(valid);
        exp_illegal_q.push_back(illegal);
        exp_vd_q.push_back(vd);
        exp_data_q.push_back(data);
        exp_name_q.push_back(name);
    endtask

    // response due now belongs to the entry driven two steps back
    task automatic check_response();
        string name;
        logic  valid;
        name  = exp_name_q.pop_front();
        valid = exp_valid_q.pop_front();
        check_value({name, " valid"}, 64'(valid), 64'(rsp_o.valid));
        check_value({name, " illegal"}, 64'(exp_illegal_q.pop_front()), 64'(rsp_o.illegal));
        if (valid) begin
            check_value({name, " vd"}, 64'(exp_vd_q.pop_front()), 64'(rsp_o.vd));
        end else begin
            void'(exp_vd_q.pop_front());
        end
        check_value({name, " data"}, exp_data_q.pop_front(), rsp_o.data);
    endtask

    task automatic drive_request(input logic active, input int idx);
        logic [5:0] f6;
        logic [2:0] vsew;
        logic       legal;
        string      name;
        // mostly the four legal opcodes
        case ($urandom % 4)
            0:       f6 = F6_VMUL;
            1:       f6 = F6_VMULH;
            2:       f6 = F6_VMULHU;
            default: f6 = F6_VMULHSU;
        endcase
        if ($urandom % 100 < 5) f6 = 6'($urandom);
        vsew = ($urandom % 100 < 8) ? 3'(4 + $urandom % 4) : 3'($urandom % 4);
        req_i.valid  = active && ($urandom % 100 < 70);
        req_i.funct6 = vmul_funct6_t'(f6);
        req_i.vsew   = vsew;
        req_i.vd     = `VMUL_TAG_W'($urandom);
        req_i.vs1    = rand_operand();
        req_i.vs2    = rand_operand();
        legal = is_legal(f6, vsew);
        name  = $sformatf("%s e%0d #%0d", op_name(f6), 8 << vsew, idx);
        if (!req_i.valid) begin
            push_expected(1'b0, 1'b0, '0, '0, $sformatf("idle #%0d", idx));
        end else if (!legal) begin
            push_expected(1'b1, 1'b1, req_i.vd, '0, {name, " illegal"});
        end else begin
            push_expected(1'b1, 1'b0, req_i.vd,
                          model_result(f6, vsew, req_i.vs1, req_i.vs2), name);
        end
    endtask

    initial begin
        cycles = 0;
        void'($urandom(60));
        rstn_i = 1'b0;
        req_i  = '0;
        // no response may show up while in reset
        repeat (RESET_CYCLES) begin
            @(posedge clk_i);
            #1;
            check_value("reset valid", 64'd0, 64'(rsp_o.valid));
        end
        rstn_i = 1'b1;
        // pipeline holds reset-state slots at release
        repeat (`VMUL_LATENCY) push_expected(1'b0, 1'b0, '0, '0, "after reset");
        for (int i = 0; i < N_TESTS; i++) begin
            @(posedge clk_i);
            #1;
            check_response();
            drive_request(1'b1, i);
        end
        // drain the last requests
        for (int i = N_TESTS; i < N_TESTS + `VMUL_LATENCY; i++) begin
            @(posedge clk_i);
            #1;
            check_response();
            drive_request(1'b0, i);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/vec_data_pkg.sv
common/vmul_op_pkg.sv
vmul/vmul_decode.sv
vmul/vmul.sv
vmul/vmul_wb.sv
source/vmul_unit.sv
tb/vmul_unit_tb.sv

// ==== vmul/vmul.sv ====
// SIMD integer multiplier, 8/16/32/64-bit elements in one 64-bit word
// sign-magnitude datapath, low or high half of each product, two cycles
`timescale 1ns/1ps

module vmul
    import vec_data_pkg::*;
    import vmul_op_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  instr_type_t instr_type_i,
    input  sew_t        sew_i,
    input  bus64_t      data_vs1_i,
    input  bus64_t      data_vs2_i,
    output bus64_t      data_vd_o
);

    ////////////////////////////////////////////////////////////
    // stage 0: signedness and magnitudes
    ////////////////////////////////////////////////////////////

    logic       mulh_0;
    logic       vs1_signed_0;
    logic       vs2_signed_0;
    logic [7:0] neg_0;
    bus64_t     mag_vs1_0;
    bus64_t     mag_vs2_0;

    // high half for everything but vmul
    assign mulh_0       = (instr_type_i != VMUL);
    // vmulhsu: vs2 signed, vs1 unsigned
    assign vs1_signed_0 = (instr_type_i == VMUL) || (instr_type_i == VMULH);
    assign vs2_signed_0 = (instr_type_i != VMULHU);

    always_comb begin
        logic       sgn1;
        logic       sgn2;
        logic       cy1;
        logic       cy2;
        logic [8:0] sum1;
        logic [8:0] sum2;
        neg_0     = '0;
        mag_vs1_0 = '0;
        mag_vs2_0 = '0;
        sgn1      = 1'b0;
        sgn2      = 1'b0;
        cy1       = 1'b0;
        cy2       = 1'b0;
        for (int b = 0; b < 8; b++) begin
            // first byte of an element
            if ((b & ((1 << sew_i) - 1)) == 0) begin
                // sign bit sits at the top of the element
                sgn1 = vs1_signed_0 & data_vs1_i[(b + (1 << sew_i)) * 8 - 1];
                sgn2 = vs2_signed_0 & data_vs2_i[(b + (1 << sew_i)) * 8 - 1];
                cy1  = sgn1;
                cy2  = sgn2;
                // product negative when exactly one source is
                neg_0[b >> sew_i] = sgn1 ^ sgn2;
            end
            // negate byte by byte, carry kept inside the element
            sum1 = {1'b0, sgn1 ? ~data_vs1_i[b*8+:8] : data_vs1_i[b*8+:8]} + cy1;
            sum2 = {1'b0, sgn2 ? ~data_vs2_i[b*8+:8] : data_vs2_i[b*8+:8]} + cy2;
            mag_vs1_0[b*8+:8] = sum1[7:0];
            mag_vs2_0[b*8+:8] = sum2[7:0];
            cy1  = sum1[8];
            cy2  = sum2[8];
        end
    end

    ////////////////////////////////////////////////////////////
    // pipeline registers
    ////////////////////////////////////////////////////////////

    sew_t        sew_1;
    sew_t        sew_2;
    logic        mulh_1;
    logic        mulh_2;
    logic [7:0]  neg_1;
    logic        neg64_2;
    bus64_t      mag_vs1_1;
    bus64_t      mag_vs2_1;
    logic [63:0] p32_1 [2][2];
    logic [63:0] p32_2 [2][2];
    bus64_t      narrow_1;
    bus64_t      narrow_2;

    // control
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sew_1   <= SEW_8;
            mulh_1  <= 1'b0;
            neg_1   <= '0;
            sew_2   <= SEW_8;
            mulh_2  <= 1'b0;
            neg64_2 <= 1'b0;
        end else begin
            sew_1   <= sew_i;
            mulh_1  <= mulh_0;
            neg_1   <= neg_0;
            sew_2   <= sew_1;
            mulh_2  <= mulh_1;
            // 64-bit mode has a single element
            neg64_2 <= neg_1[0];
        end
    end

    // datapath
    always_ff @(posedge clk_i) begin
        mag_vs1_1 <= mag_vs1_0;
        mag_vs2_1 <= mag_vs2_0;
        p32_2     <= p32_1;
        narrow_2  <= narrow_1;
    end

    ////////////////////////////////////////////////////////////
    // stage 1: partial products and narrow results
    ////////////////////////////////////////////////////////////

    logic [15:0] pp8_1 [8][8];
    logic [31:0] p16_1 [4][4];

    // every vs1 byte against every vs2 byte
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                pp8_1[i][j] = mag_vs1_1[i*8+:8] * mag_vs2_1[j*8+:8];
            end
        end
    end

    // hi*hi, cross terms and lo*lo, summed at the wider result width
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                p16_1[i][j] = pp8_1[2*i][2*j]
                            + ((pp8_1[2*i][2*j+1] + pp8_1[2*i+1][2*j]) << 8)
                            + (pp8_1[2*i+1][2*j+1] << 16);
            end
        end
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                p32_1[i][j] = p16_1[2*i][2*j]
                            + ((p16_1[2*i][2*j+1] + p16_1[2*i+1][2*j]) << 16)
                            + (p16_1[2*i+1][2*j+1] << 32);
            end
        end
    end

    // diagonal terms are the element products
    always_comb begin
        narrow_1 = '0;
        case (sew_1)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    automatic logic [15:0] full;
                    full = neg_1[i] ? -pp8_1[i][i] : pp8_1[i][i];
                    narrow_1[i*8+:8] = mulh_1 ? full[15:8] : full[7:0];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    automatic logic [31:0] full;
                    full = neg_1[i] ? -p16_1[i][i] : p16_1[i][i];
                    narrow_1[i*16+:16] = mulh_1 ? full[31:16] : full[15:0];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    automatic logic [63:0] full;
                    full = neg_1[i] ? -p32_1[i][i] : p32_1[i][i];
                    narrow_1[i*32+:32] = mulh_1 ? full[63:32] : full[31:0];
                end
            end
            // 64-bit elements finish in stage 2
            default: narrow_1 = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // stage 2: 128-bit product and output select
    ////////////////////////////////////////////////////////////

    logic [127:0] wide_2;
    logic [127:0] full_2;

    always_comb begin
        wide_2 = p32_2[0][0]
               + ((p32_2[0][1] + p32_2[1][0]) << 32)
               + (p32_2[1][1] << 64);
        // back to two's complement
        full_2 = neg64_2 ? -wide_2 : wide_2;
    end

    assign data_vd_o = (sew_2 != SEW_64) ? narrow_2 :
                       (mulh_2 ? full_2[127:64] : full_2[63:0]);

    // width that picks the output is always a legal code once out of reset
    a_sew_2_legal: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(sew_2) && (sew_2 inside {SEW_8, SEW_16, SEW_32, SEW_64}))
        else $error("vmul: stage-2 element width out of range");

endmodule

// ==== vmul/vmul_decode.sv ====
// vector multiply decoder
// funct6 and vsew to operation and element width, flags illegal requests
`timescale 1ns/1ps

module vmul_decode
    import vec_data_pkg::*;
    import vmul_op_pkg::*;
(
    input  vmul_funct6_t funct6_i,
    input  logic [2:0]   vsew_i,
    output instr_type_t  instr_type_o,
    output sew_t         sew_o,
    output logic         illegal_o
);

    logic        op_ok;
    logic        sew_ok;
    instr_type_t op_dec;
    sew_t        sew_dec;

    always_comb begin
        op_ok   = 1'b1;
        sew_ok  = 1'b1;
        op_dec  = VMUL;
        sew_dec = SEW_8;
        // opcode
        case (funct6_i)
            F6_VMUL:    op_dec = VMUL;
            F6_VMULH:   op_dec = VMULH;
            F6_VMULHU:  op_dec = VMULHU;
            F6_VMULHSU: op_dec = VMULHSU;
            default:    op_ok  = 1'b0;
        endcase
        // element width, codes 4..7 reserved
        case (vsew_i)
            3'd0:    sew_dec = SEW_8;
            3'd1:    sew_dec = SEW_16;
            3'd2:    sew_dec = SEW_32;
            3'd3:    sew_dec = SEW_64;
            default: sew_ok  = 1'b0;
        endcase
        illegal_o    = !(op_ok && sew_ok);
        // safe defaults downstream on anything illegal
        instr_type_o = illegal_o ? VMUL : op_dec;
        sew_o        = illegal_o ? SEW_8 : sew_dec;
        // even garbage or x on the inputs must give defined controls
        assert (!$isunknown({instr_type_o, sew_o}))
            else $error("vmul_decode: unknown operation or element width");
    end

endmodule

// ==== vmul/vmul_wb.sv ====
// writeback stage of the vector multiply unit
// delays valid, tag and illegal to meet the multiplier, forms the response
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_wb
    import vec_data_pkg::*;
    import vmul_op_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   valid_i,
    input  logic [`VMUL_TAG_W-1:0] vd_i,
    input  logic                   illegal_i,
    input  bus64_t                 data_i,
    output vmul_rsp_t              rsp_o
);

    // control that rides alongside the multiplier pipeline
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic [`VMUL_TAG_W-1:0] vd;
    } wb_ctl_t;

    wb_ctl_t ctl_in;
    wb_ctl_t ctl_q [`VMUL_LATENCY];

    // illegal only counts on a real request
    assign ctl_in = '{valid: valid_i, illegal: valid_i & illegal_i, vd: vd_i};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `VMUL_LATENCY; i++) begin
                ctl_q[i] <= '0;
            end
        end else begin
            ctl_q[0] <= ctl_in;
            for (int i = 1; i < `VMUL_LATENCY; i++) begin
                ctl_q[i] <= ctl_q[i-1];
            end
        end
    end

    // response, data only for a legal valid slot
    assign rsp_o.valid   = ctl_q[`VMUL_LATENCY-1].valid;
    assign rsp_o.illegal = ctl_q[`VMUL_LATENCY-1].illegal;
    assign rsp_o.vd      = ctl_q[`VMUL_LATENCY-1].vd;
    assign rsp_o.data    = (ctl_q[`VMUL_LATENCY-1].valid && !ctl_q[`VMUL_LATENCY-1].illegal)
                         ? data_i : '0;

    // an illegal request comes back flagged and with empty data
    a_illegal_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_i && illegal_i |-> ##(`VMUL_LATENCY) rsp_o.valid && rsp_o.illegal
                                                   && (rsp_o.data == '0))
        else $error("vmul_wb: illegal request returned data");

    // one response per request, exactly the latency later
    a_valid_lat: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_i |-> ##(`VMUL_LATENCY) rsp_o.valid)
        else $error("vmul_wb: response missing");
    a_no_spurious: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_o.valid |-> $past(valid_i, `VMUL_LATENCY))
        else $error("vmul_wb: response without request");

endmodule
